// ==== sources.f ====
source/csr_pkg.sv
source/csr_wr_if.sv
source/csr_access_ctrl.sv
source/csr_trap_regs.sv
source/csr_irq_regs.sv
source/csr_counters.sv
source/csr_unit.sv
bench/tb_clk_gen.sv
bench/csr_unit_chk.sv
bench/csr_unit_tb.sv

// ==== bench/csr_golden.txt ====
# op addr data expected, all hex after the op letter
# W write+read same addr, R read, T trap, I irq lines, C counter delta, M 0 clear / 1 set MIE
R F11 00000000 00000000
R F12 00000000 00000001
R F13 00000000 00000000
R F14 00000000 00000000
R 301 00000000 40001100
R 000 00000000 00000000
R 300 00000000 00001888
W 340 cafef00d cafef00d
R 340 00000000 cafef00d
W 305 00000200 00000200
R 305 00000000 00000200
W 304 ffffffff ffffffff
R 304 00000000 00000888
T 807 80000040 0badadd1
R 341 00000000 80000040
R 342 00000000 80000007
R 343 00000000 0badadd1
M 000 00000000 00000000
R 300 00000000 00001880
M 001 00000000 00000001
R 300 00000000 00001888
I 000 00000888 00000888
R 344 00000000 00000888
I 000 00000080 00000080
C B00 00000005 00000005
C B02 00000004 00000004
C C00 00000003 00000003
R C80 00000000 00000000

// ==== bench/csr_unit_tb.sv ====
// CSR unit testbench
`timescale 1ns/1ps

module csr_unit_tb import csr_pkg::*; ();

    // sample point after the falling edge, well before the next rising edge
    localparam realtime SAMPLE_DELAY  = 20.0;
    localparam int      RESET_TIMEOUT = 20;
    localparam int      MAX_LINES     = 256;
    localparam int      MAX_COUNT     = 1000;

    logic      clk;
    logic      rst_n;
    csr_addr_t csr_addr;
    logic      csr_read;
    logic      csr_wen;
    csr_addr_t csr_wr_addr;
    xlen_t     csr_wr_data;
    logic      instret_incr;
    logic      irq_software;
    logic      irq_timer;
    logic      irq_external;
    logic      cause_type;
    logic      set_cause;
    logic [3:0] trap_cause;
    logic      set_mepc;
    xlen_t     mepc_in;
    logic      set_mtval;
    xlen_t     mtval_in;
    logic      mie_clear;
    logic      mie_set;
    xlen_t     csr_data;
    logic      mstatus_mie;
    logic      mie_external;
    logic      mie_timer;
    logic      mie_sw;
    logic      mip_external;
    logic      mip_timer;
    logic      mip_sw;
    xlen_t     mtvec;
    xlen_t     mepc;

    tb_clk_gen i_clk_gen (
        .clk     (clk),
        .rst_n_o (rst_n)
    );

    csr_unit i_csr_unit (
        .clk (clk), .rst_n_i (rst_n),
        .csr_addr_i (csr_addr), .csr_read_i (csr_read),
        .csr_wen_i (csr_wen), .csr_wr_addr_i (csr_wr_addr),
        .csr_wr_data_i (csr_wr_data), .instret_incr_i (instret_incr),
        .irq_software_i (irq_software), .irq_timer_i (irq_timer),
        .irq_external_i (irq_external), .cause_type_i (cause_type),
        .set_cause_i (set_cause), .trap_cause_i (trap_cause),
        .set_mepc_i (set_mepc), .mepc_i (mepc_in),
        .set_mtval_i (set_mtval), .mtval_i (mtval_in),
        .mstatus_mie_clear_i (mie_clear), .mstatus_mie_set_i (mie_set),
        .csr_data_o (csr_data), .mstatus_mie_o (mstatus_mie),
        .mie_external_o (mie_external), .mie_timer_o (mie_timer),
        .mie_sw_o (mie_sw), .mip_external_o (mip_external),
        .mip_timer_o (mip_timer), .mip_sw_o (mip_sw),
        .mtvec_o (mtvec), .mepc_o (mepc)
    );

    // **************************************************
    // reporting
    // **************************************************
    task automatic stop_with_failure();
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR %s got %h expected %h", name, got, exp);
            stop_with_failure();
        end
    endtask

    // pulses and strobes last one cycle, the interrupt lines are levels and stay
    task automatic clear_strobes();
        csr_read     = 1'b0;
        csr_wen      = 1'b0;
        instret_incr = 1'b0;
        set_cause    = 1'b0;
        set_mepc     = 1'b0;
        set_mtval    = 1'b0;
        mie_clear    = 1'b0;
        mie_set      = 1'b0;
    endtask

    // **************************************************
    // one golden line
    // **************************************************
    task automatic run_op(input byte op, input logic [31:0] addr,
                          input logic [31:0] data, input logic [31:0] exp);
        logic [31:0] start_val;
        logic [31:0] end_val;
        logic [31:0] word;
        @(negedge clk);
        clear_strobes();
        case (op)
            "W": begin
                // reading the address being written must return the new word
                csr_wen     = 1'b1;
                csr_wr_addr = addr[11:0];
                csr_wr_data = data;
                csr_addr    = addr[11:0];
                csr_read    = 1'b1;
                #SAMPLE_DELAY;
                check_value("csr_data_o", csr_data, exp);
            end
            "R": begin
                csr_addr = addr[11:0];
                csr_read = 1'b1;
                #SAMPLE_DELAY;
                check_value("csr_data_o", csr_data, exp);
                if (addr[11:0] == ADDR_MIE) begin
                    check_value("mie_sw_o", {31'b0, mie_sw}, {31'b0, exp[BIT_MSIE]});
                    check_value("mie_timer_o", {31'b0, mie_timer}, {31'b0, exp[BIT_MTIE]});
                    check_value("mie_external_o", {31'b0, mie_external},
                                {31'b0, exp[BIT_MEIE]});
                end
            end
            "T": begin
                // addr bit 11 is the interrupt flag, addr bits 3:0 the cause code
                // a software write to mepc in the same cycle has to lose
                cause_type  = addr[11];
                trap_cause  = addr[3:0];
                set_cause   = 1'b1;
                set_mepc    = 1'b1;
                mepc_in     = data;
                set_mtval   = 1'b1;
                mtval_in    = exp;
                csr_wen     = 1'b1;
                csr_wr_addr = ADDR_MEPC;
                csr_wr_data = ~data;
                @(negedge clk);
                clear_strobes();
                #SAMPLE_DELAY;
                check_value("mepc_o", mepc, data);
            end
            "I": begin
                irq_software = data[BIT_MSIE];
                irq_timer    = data[BIT_MTIE];
                irq_external = data[BIT_MEIE];
                @(negedge clk);
                #SAMPLE_DELAY;
                word           = '0;
                word[BIT_MSIE] = mip_sw;
                word[BIT_MTIE] = mip_timer;
                word[BIT_MEIE] = mip_external;
                check_value("mip outputs", word, exp);
            end
            "M": begin
                if (addr[0]) begin
                    mie_set = 1'b1;
                end else begin
                    mie_clear = 1'b1;
                end
                @(negedge clk);
                clear_strobes();
                #SAMPLE_DELAY;
                check_value("mstatus_mie_o", {31'b0, mstatus_mie}, exp);
            end
            "C": begin
                // minstret counts with incr held high, anything else is mcycle
                if (data > MAX_COUNT) begin
                    $display("cycle count in the golden file is too large");
                    stop_with_failure();
                end
                csr_addr     = (addr[11:0] == ADDR_MINSTRET) ? ADDR_MINSTRET : ADDR_MCYCLE;
                instret_incr = (addr[11:0] == ADDR_MINSTRET);
                csr_read     = 1'b1;
                #SAMPLE_DELAY;
                start_val = csr_data;
                repeat (data) @(negedge clk);
                instret_incr = 1'b0;
                csr_addr     = addr[11:0];
                #SAMPLE_DELAY;
                end_val = csr_data;
                check_value("counter delta", end_val - start_val, exp);
            end
            default: begin
                $display("unknown operation letter in the golden file");
                stop_with_failure();
            end
        endcase
    endtask

    // **************************************************
    // main sequence
    // **************************************************
    initial begin
        int          fd;
        int          fields;
        int          line_count;
        int          ops_done;
        int          wait_count;
        string       line;
        byte         op;
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] exp;
        csr_addr     = '0;
        csr_wr_addr  = '0;
        csr_wr_data  = '0;
        irq_software = 1'b0;
        irq_timer    = 1'b0;
        irq_external = 1'b0;
        cause_type   = 1'b0;
        trap_cause   = '0;
        mepc_in      = '0;
        mtval_in     = '0;
        clear_strobes();
        line_count = 0;
        ops_done   = 0;
        wait_count = 0;

        // reset changes on a falling edge, so it is stable at the rising one
        while (rst_n !== 1'b1) begin
            @(posedge clk);
            wait_count++;
            if (wait_count > RESET_TIMEOUT) begin
                $display("reset was never released");
                stop_with_failure();
            end
        end

        // state straight after reset
        @(negedge clk);
        #SAMPLE_DELAY;
        check_value("mstatus_mie_o", {31'b0, mstatus_mie}, 32'h1);
        check_value("mtvec_o", mtvec, MTVEC_RESET);
        check_value("mie outputs", {29'b0, mie_external, mie_timer, mie_sw}, 32'h0);
        check_value("mip outputs", {29'b0, mip_external, mip_timer, mip_sw}, 32'h0);

        fd = $fopen("bench/csr_golden.txt", "r");
        if (fd == 0) begin
            $display("the golden file could not be opened");
            stop_with_failure();
        end
        while (!$feof(fd)) begin
            if (line_count >= MAX_LINES) begin
                $display("the golden file is longer than the line limit");
                stop_with_failure();
            end
            line = "";
            void'($fgets(line, fd));
            line_count++;
            // comment and blank lines carry no operation
            if (line.len() > 1 && line.getc(0) != "#") begin
                fields = $sscanf(line, "%c %h %h %h", op, addr, data, exp);
                if (fields != 4) begin
                    $display("a line of the golden file could not be parsed");
                    stop_with_failure();
                end
                run_op(op, addr, data, exp);
                ops_done++;
            end
        end
        $fclose(fd);

        @(negedge clk);
        clear_strobes();
        if (ops_done == 0) begin
            $display("no operations were found in the golden file");
            stop_with_failure();
        end else if (i_csr_unit.i_csr_unit_chk.fail_count != 0) begin
            $display("the assertion checker reported failures");
            stop_with_failure();
        end else begin
            $display("ALL TESTS PASSED");
            $finish;
        end
    end

endmodule

// ==== bench/csr_unit_chk.sv ====
// CSR unit assertions
`timescale 1ns/1ps

module csr_unit_chk (
    input logic        clk,
    input logic        rst_n_i,
    input logic        csr_read_i,
    input logic [31:0] csr_data_i,
    input logic        irq_software_i,
    input logic        irq_timer_i,
    input logic        irq_external_i,
    input logic        mip_sw_i,
    input logic        mip_timer_i,
    input logic        mip_external_i,
    input logic        set_mepc_i,
    input logic [31:0] mepc_i,
    input logic [31:0] mepc_q_i
);

    // the testbench reads this count at the end of the run
    int fail_count = 0;

    // pending bits are the interrupt lines delayed by one edge
    mip_follows_lines: assert property (@(posedge clk) disable iff (!rst_n_i)
        {mip_external_i, mip_timer_i, mip_sw_i} ==
        $past({irq_external_i, irq_timer_i, irq_software_i}))
        else begin
            fail_count++;
            $error("mip outputs do not match the interrupt lines of the previous cycle");
        end

    // an idle read port must not leak any register contents
    idle_read_is_zero: assert property (@(posedge clk)
        !csr_read_i |-> csr_data_i == 32'h0)
        else begin
            fail_count++;
            $error("csr_data_o is not zero while the read enable is low");
        end

    // a trap pulse loads mepc at the following edge
    trap_loads_mepc: assert property (@(posedge clk) disable iff (!rst_n_i)
        set_mepc_i |=> mepc_q_i == $past(mepc_i))
        else begin
            fail_count++;
            $error("mepc_o did not take the trap value after set_mepc_i");
        end

endmodule

bind csr_unit csr_unit_chk i_csr_unit_chk (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .csr_read_i     (csr_read_i),
    .csr_data_i     (csr_data_o),
    .irq_software_i (irq_software_i),
    .irq_timer_i    (irq_timer_i),
    .irq_external_i (irq_external_i),
    .mip_sw_i       (mip_sw_o),
    .mip_timer_i    (mip_timer_o),
    .mip_external_i (mip_external_o),
    .set_mepc_i     (set_mepc_i),
    .mepc_i         (mepc_i),
    .mepc_q_i       (mepc_o)
);

// ==== bench/tb_clk_gen.sv ====
// Testbench clock and reset
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk,
    output logic rst_n_o
);

    // 100 ns period
    localparam realtime HALF_PERIOD = 50.0;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // reset covers two rising edges and lifts on a falling edge
    initial begin
        rst_n_o = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n_o = 1'b1;
    end

endmodule

// ==== source/csr_unit.sv ====
// Machine mode CSR file
`timescale 1ns/1ps

module csr_unit import csr_pkg::*; (
    input  logic       clk,
    input  logic       rst_n_i,
    // read port from decode
    input  csr_addr_t  csr_addr_i,
    input  logic       csr_read_i,
    // write port from writeback
    input  logic       csr_wen_i,
    input  csr_addr_t  csr_wr_addr_i,
    input  xlen_t      csr_wr_data_i,
    input  logic       instret_incr_i,
    // interrupt lines from the timer and interrupt controllers
    input  logic       irq_software_i,
    input  logic       irq_timer_i,
    input  logic       irq_external_i,
    // trap updates from the control unit
    input  logic       cause_type_i,
    input  logic       set_cause_i,
    input  logic [3:0] trap_cause_i,
    input  logic       set_mepc_i,
    input  xlen_t      mepc_i,
    input  logic       set_mtval_i,
    input  xlen_t      mtval_i,
    input  logic       mstatus_mie_clear_i,
    input  logic       mstatus_mie_set_i,
    output xlen_t      csr_data_o,
    // state the control unit needs to take traps
    output logic       mstatus_mie_o,
    output logic       mie_external_o,
    output logic       mie_timer_o,
    output logic       mie_sw_o,
    output logic       mip_external_o,
    output logic       mip_timer_o,
    output logic       mip_sw_o,
    output xlen_t      mtvec_o,
    output xlen_t      mepc_o
);

    // strobes out to the groups, read-back words in to the mux
    csr_wr_if i_wr ();

    csr_access_ctrl i_access_ctrl (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .csr_addr_i    (csr_addr_i),
        .csr_read_i    (csr_read_i),
        .csr_wen_i     (csr_wen_i),
        .csr_wr_addr_i (csr_wr_addr_i),
        .csr_wr_data_i (csr_wr_data_i),
        .csr_data_o    (csr_data_o),
        .wr            (i_wr.ctrl)
    );

    csr_trap_regs i_trap_regs (
        .clk                 (clk),
        .rst_n_i             (rst_n_i),
        .cause_type_i        (cause_type_i),
        .set_cause_i         (set_cause_i),
        .trap_cause_i        (trap_cause_i),
        .set_mepc_i          (set_mepc_i),
        .mepc_i              (mepc_i),
        .set_mtval_i         (set_mtval_i),
        .mtval_i             (mtval_i),
        .mstatus_mie_clear_i (mstatus_mie_clear_i),
        .mstatus_mie_set_i   (mstatus_mie_set_i),
        .mstatus_mie_o       (mstatus_mie_o),
        .mtvec_o             (mtvec_o),
        .mepc_o              (mepc_o),
        .wr                  (i_wr.regs)
    );

    csr_irq_regs i_irq_regs (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .irq_software_i (irq_software_i),
        .irq_timer_i    (irq_timer_i),
        .irq_external_i (irq_external_i),
        .mie_external_o (mie_external_o),
        .mie_timer_o    (mie_timer_o),
        .mie_sw_o       (mie_sw_o),
        .mip_external_o (mip_external_o),
        .mip_timer_o    (mip_timer_o),
        .mip_sw_o       (mip_sw_o),
        .wr             (i_wr.regs)
    );

    csr_counters i_counters (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .instret_incr_i (instret_incr_i),
        .wr             (i_wr.regs)
    );

endmodule

// ==== source/csr_counters.sv ====
// Cycle and instret counters
`timescale 1ns/1ps

module csr_counters (
    input  logic   clk,
    input  logic   rst_n_i,
    input  logic   instret_incr_i,
    csr_wr_if.regs wr
);

    logic [63:0] mcycle_q;
    logic [63:0] minstret_q;

    // **************************************************
    // 64-bit counters, both halves readable
    // **************************************************
    // mcycle runs free from reset, minstret counts retire pulses
    // neither counter takes software writes
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mcycle_q   <= '0;
            minstret_q <= '0;
        end else begin
            mcycle_q <= mcycle_q + 64'd1;
            if (instret_incr_i) begin
                minstret_q <= minstret_q + 64'd1;
            end
        end
    end

    assign wr.mcycle   = mcycle_q;
    assign wr.minstret = minstret_q;

endmodule

// ==== source/csr_irq_regs.sv ====
// Interrupt enable and pending bits
`timescale 1ns/1ps

module csr_irq_regs import csr_pkg::*; (
    input  logic   clk,
    input  logic   rst_n_i,
    input  logic   irq_software_i,
    input  logic   irq_timer_i,
    input  logic   irq_external_i,
    output logic   mie_external_o,
    output logic   mie_timer_o,
    output logic   mie_sw_o,
    output logic   mip_external_o,
    output logic   mip_timer_o,
    output logic   mip_sw_o,
    csr_wr_if.regs wr
);

    logic msie_q;
    logic mtie_q;
    logic meie_q;
    logic msip_q;
    logic mtip_q;
    logic meip_q;

    // enables keep only the three machine bits of the written word
    // pending bits sample the lines every edge, so they lag by one cycle
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            msie_q <= 1'b0;
            mtie_q <= 1'b0;
            meie_q <= 1'b0;
            msip_q <= 1'b0;
            mtip_q <= 1'b0;
            meip_q <= 1'b0;
        end else begin
            if (wr.mie_we) begin
                msie_q <= wr.wr_data[BIT_MSIE];
                mtie_q <= wr.wr_data[BIT_MTIE];
                meie_q <= wr.wr_data[BIT_MEIE];
            end
            msip_q <= irq_software_i;
            mtip_q <= irq_timer_i;
            meip_q <= irq_external_i;
        end
    end

    // mie and mip share one layout, all other bits read zero
    always_comb begin
        wr.mie           = '0;
        wr.mie[BIT_MSIE] = msie_q;
        wr.mie[BIT_MTIE] = mtie_q;
        wr.mie[BIT_MEIE] = meie_q;
        wr.mip           = '0;
        wr.mip[BIT_MSIE] = msip_q;
        wr.mip[BIT_MTIE] = mtip_q;
        wr.mip[BIT_MEIE] = meip_q;
    end

    assign mie_sw_o       = msie_q;
    assign mie_timer_o    = mtie_q;
    assign mie_external_o = meie_q;
    assign mip_sw_o       = msip_q;
    assign mip_timer_o    = mtip_q;
    assign mip_external_o = meip_q;

endmodule

// ==== source/csr_trap_regs.sv ====
// Trap handling registers
`timescale 1ns/1ps

module csr_trap_regs import csr_pkg::*; (
    input  logic       clk,
    input  logic       rst_n_i,
    input  logic       cause_type_i,
    input  logic       set_cause_i,
    input  logic [3:0] trap_cause_i,
    input  logic       set_mepc_i,
    input  xlen_t      mepc_i,
    input  logic       set_mtval_i,
    input  xlen_t      mtval_i,
    input  logic       mstatus_mie_clear_i,
    input  logic       mstatus_mie_set_i,
    output logic       mstatus_mie_o,
    output xlen_t      mtvec_o,
    output xlen_t      mepc_o,
    csr_wr_if.regs     wr
);

    logic    mie_q;
    logic    mpie_q;
    xlen_t   mtvec_q;
    xlen_t   mscratch_q;
    xlen_t   mepc_q;
    xlen_t   mtval_q;
    mcause_t mcause_q;
    mcause_t mcause_trap;

    // **************************************************
    // mstatus
    // **************************************************
    // software write beats the clear pulse, which beats the set pulse
    // clear saves MIE into MPIE on trap entry, set restores it on mret
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mie_q  <= 1'b1;
            mpie_q <= 1'b1;
        end else if (wr.mstatus_we) begin
            mie_q  <= wr.wr_data[BIT_MIE];
            mpie_q <= wr.wr_data[BIT_MPIE];
        end else if (mstatus_mie_clear_i) begin
            mpie_q <= mie_q;
            mie_q  <= 1'b0;
        end else if (mstatus_mie_set_i) begin
            mie_q  <= mpie_q;
            mpie_q <= 1'b1;
        end
    end

    // only MIE, MPIE and the fixed machine-mode MPP are visible
    always_comb begin
        wr.mstatus                      = '0;
        wr.mstatus[BIT_MPP_LO+1 -: 2]   = PRIV_M;
        wr.mstatus[BIT_MPIE]            = mpie_q;
        wr.mstatus[BIT_MIE]             = mie_q;
    end

    // **************************************************
    // trap vector, epc, cause and value
    // **************************************************
    // hardware fills mcause by field, with the reserved bits cleared
    always_comb begin
        mcause_trap.f.intr = cause_type_i;
        mcause_trap.f.rsvd = '0;
        mcause_trap.f.code = trap_cause_i;
    end

    // trap pulses take priority over a software write in the same cycle
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mtvec_q  <= MTVEC_RESET;
            mepc_q   <= '0;
            mcause_q <= '0;
            mtval_q  <= '0;
        end else begin
            if (wr.mtvec_we) begin
                mtvec_q <= wr.wr_data;
            end
            if (set_mepc_i) begin
                mepc_q <= mepc_i;
            end else if (wr.mepc_we) begin
                mepc_q <= wr.wr_data;
            end
            if (set_cause_i) begin
                mcause_q <= mcause_trap;
            end else if (wr.mcause_we) begin
                mcause_q.raw <= wr.wr_data;
            end
            if (set_mtval_i) begin
                mtval_q <= mtval_i;
            end else if (wr.mtval_we) begin
                mtval_q <= wr.wr_data;
            end
        end
    end

    // scratch word for the trap handler, written only by software
    always_ff @(posedge clk) begin
        if (wr.mscratch_we) begin
            mscratch_q <= wr.wr_data;
        end
    end

    assign wr.mtvec    = mtvec_q;
    assign wr.mscratch = mscratch_q;
    assign wr.mepc     = mepc_q;
    assign wr.mcause   = mcause_q.raw;
    assign wr.mtval    = mtval_q;

    assign mstatus_mie_o = mie_q;
    assign mtvec_o       = mtvec_q;
    assign mepc_o        = mepc_q;

endmodule

// ==== source/csr_access_ctrl.sv ====
// CSR address decode and read mux
`timescale 1ns/1ps

module csr_access_ctrl import csr_pkg::*; (
    input  logic      clk,
    input  logic      rst_n_i,
    input  csr_addr_t csr_addr_i,
    input  logic      csr_read_i,
    input  logic      csr_wen_i,
    input  csr_addr_t csr_wr_addr_i,
    input  xlen_t     csr_wr_data_i,
    output xlen_t     csr_data_o,
    csr_wr_if.ctrl    wr
);

    logic  rd_live_q;
    logic  bypass;
    xlen_t rd_word;

    // **************************************************
    // write decode
    // **************************************************
    // write data goes to every group, only the matching strobe fires
    assign wr.wr_data     = csr_wr_data_i;
    assign wr.mstatus_we  = csr_wen_i && (csr_wr_addr_i == ADDR_MSTATUS);
    assign wr.mie_we      = csr_wen_i && (csr_wr_addr_i == ADDR_MIE);
    assign wr.mtvec_we    = csr_wen_i && (csr_wr_addr_i == ADDR_MTVEC);
    assign wr.mscratch_we = csr_wen_i && (csr_wr_addr_i == ADDR_MSCRATCH);
    assign wr.mepc_we     = csr_wen_i && (csr_wr_addr_i == ADDR_MEPC);
    assign wr.mcause_we   = csr_wen_i && (csr_wr_addr_i == ADDR_MCAUSE);
    assign wr.mtval_we    = csr_wen_i && (csr_wr_addr_i == ADDR_MTVAL);

    // **************************************************
    // read select
    // **************************************************
    // unknown addresses and the read-only counters' neighbours read zero
    always_comb begin
        rd_word = '0;
        case (csr_addr_i)
            ADDR_MVENDORID: rd_word = MVENDORID_VAL;
            ADDR_MARCHID:   rd_word = MARCHID_VAL;
            ADDR_MIMPID:    rd_word = MIMPID_VAL;
            ADDR_MHARTID:   rd_word = MHARTID_VAL;
            ADDR_MISA:      rd_word = MISA_VAL;
            ADDR_MSTATUS:   rd_word = wr.mstatus;
            ADDR_MIE:       rd_word = wr.mie;
            ADDR_MIP:       rd_word = wr.mip;
            ADDR_MTVEC:     rd_word = wr.mtvec;
            ADDR_MSCRATCH:  rd_word = wr.mscratch;
            ADDR_MEPC:      rd_word = wr.mepc;
            ADDR_MCAUSE:    rd_word = wr.mcause;
            ADDR_MTVAL:     rd_word = wr.mtval;
            // the user aliases share the machine cycle counter
            ADDR_MCYCLE, ADDR_CYCLE:   rd_word = wr.mcycle[31:0];
            ADDR_MCYCLEH, ADDR_CYCLEH: rd_word = wr.mcycle[63:32];
            ADDR_MINSTRET:  rd_word = wr.minstret[31:0];
            ADDR_MINSTRETH: rd_word = wr.minstret[63:32];
            default:        rd_word = '0;
        endcase
    end

    // a write landing on the address being read this cycle is forwarded,
    // so the reader sees the value before it reaches the register
    assign bypass = csr_wen_i && (csr_wr_addr_i == csr_addr_i) && (csr_addr_i != '0);

    // this flag is cleared by the asynchronous reset and keeps read data
    // at zero until the first edge after reset is released
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rd_live_q <= 1'b0;
        end else begin
            rd_live_q <= 1'b1;
        end
    end

    // address zero never holds a register and always reads as zero
    always_comb begin
        if (!rd_live_q || !csr_read_i || (csr_addr_i == '0)) begin
            csr_data_o = '0;
        end else if (bypass) begin
            csr_data_o = csr_wr_data_i;
        end else begin
            csr_data_o = rd_word;
        end
    end

endmodule

// ==== source/csr_wr_if.sv ====
// CSR write and read-back bus
`timescale 1ns/1ps

interface csr_wr_if import csr_pkg::*; ();

    // shared write data and one strobe per writable register
    xlen_t wr_data;
    logic  mstatus_we;
    logic  mie_we;
    logic  mtvec_we;
    logic  mscratch_we;
    logic  mepc_we;
    logic  mcause_we;
    logic  mtval_we;

    // read-back words, each driven by the group that owns the register
    xlen_t       mstatus;
    xlen_t       mie;
    xlen_t       mip;
    xlen_t       mtvec;
    xlen_t       mscratch;
    xlen_t       mepc;
    xlen_t       mcause;
    xlen_t       mtval;
    logic [63:0] mcycle;
    logic [63:0] minstret;

    // the control side decodes addresses and picks the read word
    modport ctrl (
        output wr_data, mstatus_we, mie_we, mtvec_we, mscratch_we,
               mepc_we, mcause_we, mtval_we,
        input  mstatus, mie, mip, mtvec, mscratch, mepc, mcause, mtval,
               mcycle, minstret
    );

    // register groups see strobes only and never an address
    modport regs (
        input  wr_data, mstatus_we, mie_we, mtvec_we, mscratch_we,
               mepc_we, mcause_we, mtval_we,
        output mstatus, mie, mip, mtvec, mscratch, mepc, mcause, mtval,
               mcycle, minstret
    );

endinterface

// ==== source/csr_pkg.sv ====
// Machine CSR definitions
package csr_pkg;

    // data word and address widths are fixed by RV32
    typedef logic [31:0] xlen_t;
    typedef logic [11:0] csr_addr_t;

    // **************************************************
    // standard machine and user CSR addresses
    // **************************************************
    localparam csr_addr_t ADDR_MSTATUS   = 12'h300;
    localparam csr_addr_t ADDR_MISA      = 12'h301;
    localparam csr_addr_t ADDR_MIE       = 12'h304;
    localparam csr_addr_t ADDR_MTVEC     = 12'h305;
    localparam csr_addr_t ADDR_MSCRATCH  = 12'h340;
    localparam csr_addr_t ADDR_MEPC      = 12'h341;
    localparam csr_addr_t ADDR_MCAUSE    = 12'h342;
    localparam csr_addr_t ADDR_MTVAL     = 12'h343;
    localparam csr_addr_t ADDR_MIP       = 12'h344;
    localparam csr_addr_t ADDR_MCYCLE    = 12'hB00;
    localparam csr_addr_t ADDR_MINSTRET  = 12'hB02;
    localparam csr_addr_t ADDR_MCYCLEH   = 12'hB80;
    localparam csr_addr_t ADDR_MINSTRETH = 12'hB82;
    // user-level aliases that read the machine cycle counter
    localparam csr_addr_t ADDR_CYCLE     = 12'hC00;
    localparam csr_addr_t ADDR_CYCLEH    = 12'hC80;
    localparam csr_addr_t ADDR_MVENDORID = 12'hF11;
    localparam csr_addr_t ADDR_MARCHID   = 12'hF12;
    localparam csr_addr_t ADDR_MIMPID    = 12'hF13;
    localparam csr_addr_t ADDR_MHARTID   = 12'hF14;

    // **************************************************
    // identity and reset values
    // **************************************************
    // zero vendor means a non-commercial implementation
    localparam xlen_t MVENDORID_VAL = 32'h0000_0000;
    localparam xlen_t MARCHID_VAL   = 32'h0000_0001;
    localparam xlen_t MIMPID_VAL    = 32'h0000_0000;
    localparam xlen_t MHARTID_VAL   = 32'h0000_0000;
    // MXL = 1 for 32 bits, extension bits 8 (I) and 12 (M)
    localparam xlen_t MISA_VAL      = 32'h4000_1100;
    // direct mode trap vector, word aligned
    localparam xlen_t MTVEC_RESET   = 32'h0000_0100;

    // **************************************************
    // field positions
    // **************************************************
    // mstatus global enable and its saved copy
    localparam int BIT_MIE  = 3;
    localparam int BIT_MPIE = 7;
    // the same positions serve in both mie and mip
    localparam int BIT_MSIE = 3;
    localparam int BIT_MTIE = 7;
    localparam int BIT_MEIE = 11;
    // MPP sits in bits 12:11 and only machine mode exists here
    localparam int         BIT_MPP_LO = 11;
    localparam logic [1:0] PRIV_M     = 2'b11;

    // mcause is written whole by software and by field from the trap logic
    typedef struct packed {
        logic        intr;
        logic [26:0] rsvd;
        logic [3:0]  code;
    } mcause_fields_t;

    typedef union packed {
        xlen_t          raw;
        mcause_fields_t f;
    } mcause_t;

endpackage
